// ==== Makefile ====
# Verilator build and run of the sprite line engine testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_obj_line -f flist.f

run: compile
	@out="$$(./obj_dir/Vtb_obj_line)"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// ==== flist.f ====
+incdir+.
obj_pkg.sv
obj_attr_fetch.sv
obj_draw.sv
obj_line_buffer.sv
obj_line_top.sv
tb_obj_line.sv

// ==== obj_attr_fetch.sv ====
// ====================
// stage 1 of the sprite line engine
// host fills the 64-byte object table, then a line_start walks all
// objects in order and offers one attribute struct each by req/ack
// ====================
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_attr_fetch (
    input  logic                   clk,
    input  logic                   rst,
    // host table port
    input  logic                   tbl_we,
    input  logic [`OBJ_TBL_AW-1:0] tbl_addr,
    input  logic [7:0]             tbl_data,
    // line control
    input  logic                   line_start,
    input  logic [7:0]             line_num,
    output logic                   busy,
    output logic                   line_done,
    // to draw stage
    output logic                   attr_req,
    input  logic                   attr_ack,
    output obj_pkg::obj_attr_t     attr,
    output logic [7:0]             line_num_q,
    // from line buffer
    input  logic                   done_in
);

    typedef enum logic [2:0] {
        F_IDLE,
        F_READ,     // table read of current object
        F_REQ,      // attr offered, wait for ack
        F_ACKLOW,   // wait for ack to drop
        F_DONE      // all objects handed out, wait for buffer
    } fstate_t;

    fstate_t                 state;
    logic [`OBJ_IDX_W-1:0]   obj_idx;
    logic                    done_pend;     // buffer finished early
    logic                    obj_last;

    // four bytes per object: code low, attribute, Y, X
    logic [3:0][7:0] tbl [0:`OBJ_COUNT-1];
    logic [3:0][7:0] rd_word;

    always_ff @(posedge clk) begin
        if (tbl_we)
            tbl[tbl_addr[`OBJ_TBL_AW-1:2]][tbl_addr[1:0]] <= tbl_data;
        if (state == F_READ)
            rd_word <= tbl[obj_idx];    // attr shows up next cycle
    end

    assign obj_last = (obj_idx == `OBJ_IDX_W'(`OBJ_COUNT - 1));

    // unpack the attribute byte, rd_word is stable while req is high
    assign attr = '{
        code:  {rd_word[1][7:6], rd_word[0]},
        pal:   rd_word[1][5:4],
        vflip: rd_word[1][3],
        hflip: rd_word[1][2],
        y:     rd_word[2],
        x:     {rd_word[1][0], rd_word[3]},
        last:  obj_last
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= F_IDLE;
            obj_idx    <= '0;
            busy       <= 1'b0;
            line_done  <= 1'b0;
            attr_req   <= 1'b0;
            done_pend  <= 1'b0;
            line_num_q <= '0;
        end else begin
            line_done <= 1'b0;                              // one-cycle pulse
            if (busy && done_in)
                done_pend <= 1'b1;
            case (state)
                F_IDLE: if (line_start) begin               // ignored while busy
                    line_num_q <= line_num;
                    busy       <= 1'b1;
                    obj_idx    <= '0;
                    done_pend  <= 1'b0;
                    state      <= F_READ;
                end
                F_READ: begin
                    attr_req <= 1'b1;
                    state    <= F_REQ;
                end
                F_REQ: if (attr_ack) begin
                    attr_req <= 1'b0;
                    state    <= F_ACKLOW;
                end
                F_ACKLOW: if (!attr_ack) begin
                    if (obj_last) begin
                        state <= F_DONE;
                    end else begin
                        obj_idx <= obj_idx + 1'b1;
                        state   <= F_READ;
                    end
                end
                F_DONE: if (done_pend || done_in) begin
                    busy      <= 1'b0;                      // falls with line_done
                    line_done <= 1'b1;
                    state     <= F_IDLE;
                end
                default: state <= F_IDLE;
            endcase
        end
    end

endmodule

// ==== obj_config.svh ====
// ====================
// build-time sizes for the sprite line engine
// include in any module that needs table, line or sprite sizes
// ====================
`ifndef OBJ_CONFIG_SVH
`define OBJ_CONFIG_SVH

// object table
`define OBJ_COUNT   16          // objects per table
`define OBJ_IDX_W   4           // bits to index one object
`define OBJ_TBL_AW  6           // byte address, object then byte

// line and sprite geometry
`define OBJ_LINE_W  256         // visible pixels per line
`define OBJ_SIZE    16          // sprite height and width

// colour code that is never written to the line
`define OBJ_TRANSP  15

`endif

// ==== obj_draw.sv ====
// ====================
// stage 2 of the sprite line engine
// zone test, graphics ROM fetch of four quarters per object and
// planar depack into four-pixel groups for the line buffer
// ====================
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_draw (
    input  logic                clk,
    input  logic                rst,
    // from fetch stage
    input  logic                attr_req,
    output logic                attr_ack,
    input  obj_pkg::obj_attr_t  attr,
    input  logic [7:0]          line_num_q,
    // graphics ROM
    output logic                rom_req,
    output logic [15:0]         rom_addr,
    input  logic                rom_ack,
    input  logic [15:0]         rom_data,
    // to line buffer
    output logic                grp_req,
    input  logic                grp_ack,
    output obj_pkg::pxl_group_t grp,
    output logic                grp_last
);

    typedef enum logic [1:0] {
        D_IDLE,     // decide on the held object
        D_ROM,      // rom_req high, wait for ack
        D_ROM_END,  // wait for rom_ack to drop
        D_OUT       // hand the group over once output is free
    } dstate_t;

    dstate_t            state;
    obj_pkg::obj_attr_t cur;        // object being drawn
    logic               cur_valid;
    logic [1:0]         q;          // on-screen column quarter
    logic [15:0]        word;       // latched ROM word
    logic [7:0]         diff;
    logic [3:0]         row;
    logic               in_zone;
    logic               out_free;

    // depack one planar word, bit 3 of each nibble is leftmost unless flipped
    function automatic logic [3:0][3:0] depack(input logic [15:0] w, input logic flip);
        logic [3:0][3:0] c;
        int              b;
        for (int i = 0; i < 4; i++) begin
            b    = flip ? i : 3 - i;
            c[i] = {w[12+b], w[8+b], w[4+b], w[b]};     // plane 3 is msb
        end
        return c;
    endfunction

    assign diff     = line_num_q - cur.y;               // modulo 256
    assign in_zone  = (diff < 8'(`OBJ_SIZE));
    assign row      = diff[3:0] ^ {4{cur.vflip}};
    assign out_free = !grp_req && !grp_ack;             // previous group fully closed

    // code, col[1], row, col[0]; flip picks the mirrored quarter
    assign rom_addr = {cur.code, q[1] ^ cur.hflip, row, q[0] ^ cur.hflip};

    always_ff @(posedge clk) begin
        if (rom_req && rom_ack)
            word <= rom_data;
        // accept a new object as soon as the previous one is released
        if (attr_req && !attr_ack && !cur_valid)
            cur <= attr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= D_IDLE;
            cur_valid <= 1'b0;
            attr_ack  <= 1'b0;
            rom_req   <= 1'b0;
            grp_req   <= 1'b0;
            grp_last  <= 1'b0;
            q         <= '0;
        end else begin
            // input side handshake
            if (attr_req && !attr_ack && !cur_valid) begin
                cur_valid <= 1'b1;
                attr_ack  <= 1'b1;
            end else if (attr_ack && !attr_req) begin
                attr_ack <= 1'b0;
            end
            // output side, req drops on ack
            if (grp_req && grp_ack)
                grp_req <= 1'b0;

            case (state)
                D_IDLE: if (cur_valid) begin
                    if (in_zone) begin
                        q       <= '0;
                        rom_req <= 1'b1;
                        state   <= D_ROM;
                    end else if (!cur.last) begin
                        cur_valid <= 1'b0;                  // skipped, no ROM access
                    end else if (out_free) begin
                        // closing empty group so the buffer sees the end of line
                        grp.x    <= cur.x;
                        grp.pal  <= cur.pal;
                        grp.col  <= {4{4'(`OBJ_TRANSP)}};
                        grp_last <= 1'b1;
                        grp_req  <= 1'b1;
                        cur_valid <= 1'b0;
                    end
                end
                D_ROM: if (rom_ack) begin
                    rom_req <= 1'b0;
                    state   <= D_ROM_END;
                end
                D_ROM_END: if (!rom_ack)
                    state <= D_OUT;
                D_OUT: if (out_free) begin
                    grp.x    <= cur.x + {5'd0, q, 2'b00};   // 4 pixels per quarter
                    grp.pal  <= cur.pal;
                    grp.col  <= depack(word, cur.hflip);
                    grp_last <= cur.last && (q == 2'd3);
                    grp_req  <= 1'b1;
                    if (q == 2'd3) begin
                        cur_valid <= 1'b0;                  // next attr may come in
                        state     <= D_IDLE;
                    end else begin
                        q       <= q + 1'b1;
                        rom_req <= 1'b1;                    // overlaps buffer write
                        state   <= D_ROM;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

endmodule

// ==== obj_line_buffer.sv ====
// ====================
// stage 3 of the sprite line engine
// one-line pixel RAM, first writer wins so lower objects stay on top
// readout returns the pixel a cycle later and clears the entry
// ====================
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_line_buffer (
    input  logic                clk,
    input  logic                rst,
    // from draw stage
    input  logic                grp_req,
    output logic                grp_ack,
    input  obj_pkg::pxl_group_t grp,
    input  logic                grp_last,
    output logic                done_in,
    // readout
    input  logic                rd_en,
    input  logic [7:0]          rd_addr,
    output obj_pkg::buf_entry_t rd_pixel
);

    localparam obj_pkg::buf_entry_t BLANK = '{pal: 2'd0, col: 4'(`OBJ_TRANSP)};

    obj_pkg::buf_entry_t    line_ram [0:`OBJ_LINE_W-1];
    logic [`OBJ_LINE_W-1:0] valid;

    obj_pkg::pxl_group_t    g;          // latched group
    logic                   g_last;
    logic                   writing;
    logic [1:0]             cnt;        // pixel within group
    logic [9:0]             px;         // full X, may pass the line end
    logic [3:0]             col;
    logic                   wr;

    assign px  = {1'b0, g.x} + {8'd0, cnt};
    assign col = g.col[cnt];
    // skip transparent, off-line and already claimed pixels
    assign wr  = writing && (col != 4'(`OBJ_TRANSP)) &&
                 (px < 10'(`OBJ_LINE_W)) && !valid[px[7:0]];

    always_ff @(posedge clk) begin
        if (wr)
            line_ram[px[7:0]] <= '{pal: g.pal, col: col};
        if (rd_en)
            rd_pixel <= valid[rd_addr] ? line_ram[rd_addr] : BLANK;
        if (grp_req && !grp_ack && !writing) begin
            g      <= grp;
            g_last <= grp_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid   <= '0;
            writing <= 1'b0;
            cnt     <= '0;
            grp_ack <= 1'b0;
            done_in <= 1'b0;
        end else begin
            done_in <= 1'b0;
            if (rd_en)
                valid[rd_addr] <= 1'b0;     // read clears
            if (wr)
                valid[px[7:0]] <= 1'b1;
            if (grp_req && !grp_ack && !writing) begin
                writing <= 1'b1;
                cnt     <= '0;
            end else if (writing) begin
                cnt <= cnt + 1'b1;
                if (cnt == 2'd3) begin      // fourth pixel goes in this cycle
                    writing <= 1'b0;
                    grp_ack <= 1'b1;
                    done_in <= g_last;
                end
            end else if (grp_ack && !grp_req) begin
                grp_ack <= 1'b0;
            end
        end
    end

endmodule

// ==== obj_line_input.txt ====
# records, fields in hex: P y | O obj code_lo attr y x | R addr word | L line rom_reqs
# E x count pal col col_step sets expected pixels | V reads the line back and compares
V
# sprite 012 row 5, colours 1..e, f, 0 left to right
R 048a 016a
R 048b 1e6a
R 04aa f16a
R 04ab ee6a
# sprite 155 row d, stored mirrored so hflip gives the same colours
R 557b 0865
R 557a 8765
R 555b f865
R 555a 7765
# one object, no flip
P f0
O 3 12 20 20 40
L 25 4
E 40 e 2 1 1
E 4f 1 2 0 0
V
# hflip and vflip, line 62 is row 2 inverted
P f0
O 0 55 5c 60 80
L 62 4
E 80 e 1 1 1
E 8f 1 1 0 0
V
# object 1 over object 5, 5 shows through at 1e
P f0
O 1 12 30 30 10
O 5 55 5c 33 18
L 35 8
E 10 e 3 1 1
E 1e 1 1 7 0
E 1f 1 3 0 0
E 20 6 1 9 1
E 27 1 1 0 0
V
# 4 and 6 just outside the band, 9 and the tail of 2 past x ff
P f0
O 2 12 20 70 f8
O 4 12 20 76 00
O 6 12 20 65 40
O 9 12 01 70 10
L 75 8
E f8 8 2 1 1
V
# same table, nothing in zone, previous pixels must be gone
L 50 0
V

// ==== obj_line_top.sv ====
// ====================
// sprite line engine top
// chains attribute fetch, draw and line buffer stages
// ROM is external, readout only after line_done
// ====================
`timescale 1ns/1ps

module obj_line_top (
    input  logic                clk,
    input  logic                rst,
    // host table and line control
    input  logic                tbl_we,
    input  logic [5:0]          tbl_addr,
    input  logic [7:0]          tbl_data,
    input  logic                line_start,
    input  logic [7:0]          line_num,
    output logic                busy,
    output logic                line_done,
    // graphics ROM
    output logic                rom_req,
    output logic [15:0]         rom_addr,
    input  logic                rom_ack,
    input  logic [15:0]         rom_data,
    // line readout
    input  logic                rd_en,
    input  logic [7:0]          rd_addr,
    output obj_pkg::buf_entry_t rd_pixel
);

    logic                attr_req;
    logic                attr_ack;
    obj_pkg::obj_attr_t  attr;
    logic [7:0]          line_num_q;
    logic                grp_req;
    logic                grp_ack;
    obj_pkg::pxl_group_t grp;
    logic                grp_last;
    logic                done_in;

    obj_attr_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .tbl_we     (tbl_we),
        .tbl_addr   (tbl_addr),
        .tbl_data   (tbl_data),
        .line_start (line_start),
        .line_num   (line_num),
        .busy       (busy),
        .line_done  (line_done),
        .attr_req   (attr_req),
        .attr_ack   (attr_ack),
        .attr       (attr),
        .line_num_q (line_num_q),
        .done_in    (done_in)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .attr_req   (attr_req),
        .attr_ack   (attr_ack),
        .attr       (attr),
        .line_num_q (line_num_q),
        .rom_req    (rom_req),
        .rom_addr   (rom_addr),
        .rom_ack    (rom_ack),
        .rom_data   (rom_data),
        .grp_req    (grp_req),
        .grp_ack    (grp_ack),
        .grp        (grp),
        .grp_last   (grp_last)
    );

    obj_line_buffer u_buf (
        .clk        (clk),
        .rst        (rst),
        .grp_req    (grp_req),
        .grp_ack    (grp_ack),
        .grp        (grp),
        .grp_last   (grp_last),
        .done_in    (done_in),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_pixel   (rd_pixel)
    );

endmodule

// ==== obj_pkg.sv ====
// ====================
// payload types passed between the sprite line stages
// referenced by scoped name from every stage and the top
// ====================
package obj_pkg;

    // one object's drawing data, fetch to draw
    typedef struct packed {
        logic [9:0] code;       // tile code, high bits from attribute byte
        logic [1:0] pal;
        logic       vflip;
        logic       hflip;
        logic [7:0] y;
        logic [8:0] x;          // bit 8 from attribute byte
        logic       last;       // final object of the table
    } obj_attr_t;

    // four pixels of one sprite quarter, draw to buffer
    typedef struct packed {
        logic [8:0]      x;     // screen X of col[0]
        logic [1:0]      pal;
        logic [3:0][3:0] col;   // col[0] is leftmost
    } pxl_group_t;

    // one line buffer pixel
    typedef struct packed {
        logic [1:0] pal;
        logic [3:0] col;
    } buf_entry_t;

endpackage

// ==== tb_obj_line.sv ====
// ====================
// testbench for the sprite line engine
// replays obj_line_input.txt (table and ROM loads, line runs, readouts)
// and models the graphics ROM with random ack delays
// ====================
`timescale 1ns/1ps

module tb_obj_line;

    logic                clk;
    logic                rst;
    logic                tbl_we;
    logic [5:0]          tbl_addr;
    logic [7:0]          tbl_data;
    logic                line_start;
    logic [7:0]          line_num;
    logic                busy;
    logic                line_done;
    logic                rom_req;
    logic [15:0]         rom_addr;
    logic                rom_ack;
    logic [15:0]         rom_data;
    logic                rd_en;
    logic [7:0]          rd_addr;
    obj_pkg::buf_entry_t rd_pixel;

    logic [15:0] rom [0:65535];     // graphics ROM image
    logic        rom_loaded [0:65535];  // word given by an R record
    logic [5:0]  exp_px [0:255];    // expected {pal, col} per x
    logic [31:0] rng;
    logic        rom_busy;          // ack delay running
    int          rom_wait;
    int          rom_reqs;          // ROM handshakes this line
    int          pulses;            // line_done pulses this line
    int          exp_reqs;
    int          exp_pulses;
    int          errors;
    int          checks;
    logic        abort;

    obj_line_top u_dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, act, exp);
        end
    endtask

    task automatic next_cycle();    // to the drive point after the next edge
        @(posedge clk);
        #1;
    endtask

    task automatic write_byte(input logic [5:0] a, input logic [7:0] d);
        tbl_we   = 1'b1;
        tbl_addr = a;
        tbl_data = d;
        next_cycle();
        tbl_we   = 1'b0;
    endtask

    // code low, attribute, Y, X
    task automatic write_object(input int idx, input int b0, input int b1,
                                input int b2, input int b3);
        write_byte(6'(idx * 4), 8'(b0));
        write_byte(6'(idx * 4 + 1), 8'(b1));
        write_byte(6'(idx * 4 + 2), 8'(b2));
        write_byte(6'(idx * 4 + 3), 8'(b3));
    endtask

    task automatic park(input int y);       // every object to one Y with code 0
        for (int i = 0; i < 16; i++)
            write_object(i, 0, 0, y, 0);
    endtask

    task automatic expect_run(input int x, input int n, input int pal, input int col,
                              input int step);
        for (int k = 0; k < n; k++)
            exp_px[x + k] = 6'((pal << 4) | ((col + k * step) & 15));
    endtask

    task automatic run_line(input logic [7:0] n);
        int t;
        line_num   = n;
        line_start = 1'b1;
        pulses     = 0;
        rom_reqs   = 0;
        next_cycle();
        line_start = 1'b0;
        check("busy", 32'(busy), 32'd1);        // up one cycle after start
        for (t = 0; t < 2000 && !line_done; t++)
            next_cycle();
        if (!line_done) begin
            $display("timeout: line %0h never signalled line_done", n);
            errors++;
            abort = 1'b1;
        end else begin
            check("busy", 32'(busy), 32'd0);    // drops with line_done
        end
        for (int i = 0; i < 256; i++)
            exp_px[i] = {2'd0, 4'hf};
    endtask

    // full readout where pixel a shows up one cycle after its address
    task automatic read_line();
        rd_en   = 1'b1;
        rd_addr = 8'd0;
        for (int a = 0; a < 256; a++) begin
            next_cycle();
            check($sformatf("rd_pixel[%0d]", a), 32'(rd_pixel), 32'(exp_px[a]));
            rd_addr = 8'(a + 1);
        end
        rd_en = 1'b0;
        check("line_done pulses", pulses, exp_pulses);
        check("rom requests", rom_reqs, exp_reqs);
    endtask

    // graphics ROM model acking 1 to 4 cycles after req
    always begin
        next_cycle();
        if (rst) begin
            rom_ack  = 1'b0;
            rom_busy = 1'b0;
        end else if (rom_ack) begin
            if (!rom_req)
                rom_ack = 1'b0;             // release after req drops
        end else if (rom_req) begin
            if (!rom_busy) begin
                rng      = xorshift(rng);
                rom_wait = 1 + rng[1:0];
                rom_busy = 1'b1;
                rom_reqs++;
            end
            if (rom_wait > 1) begin
                rom_wait--;
            end else begin
                check($sformatf("rom_loaded[%0h]", rom_addr),
                      32'(rom_loaded[rom_addr]), 32'd1);    // fetch must hit a file word
                rom_data = rom[rom_addr];
                rom_ack  = 1'b1;
                rom_busy = 1'b0;
            end
        end
    end

    always begin                            // line_done pulse counter
        next_cycle();
        if (line_done)
            pulses++;
    end

    initial begin
        int               fd;
        int               n;
        int               a, b, c, d, e;
        logic [7:0]       cmd;
        logic [8*160-1:0] text;
        clk        = 1'b0;
        rst        = 1'b1;
        tbl_we     = 1'b0;
        tbl_addr   = '0;
        tbl_data   = '0;
        line_start = 1'b0;
        line_num   = '0;
        rom_ack    = 1'b0;
        rom_data   = '0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        rng        = 32'd86092;
        rom_busy   = 1'b0;
        rom_wait   = 0;
        rom_reqs   = 0;
        pulses     = 0;
        exp_reqs   = 0;
        exp_pulses = 0;
        errors     = 0;
        checks     = 0;
        abort      = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            rom[i]        = {i[7:0], i[15:8]} ^ 16'h3c5a;  // filler for words not in the file
            rom_loaded[i] = 1'b0;
        end
        for (int i = 0; i < 256; i++)
            exp_px[i] = {2'd0, 4'hf};
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check("busy", 32'(busy), 32'd0);
        check("rom_req", 32'(rom_req), 32'd0);

        fd = $fopen("obj_line_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open obj_line_input.txt");
            errors++;
            abort = 1'b1;
        end
        while (!abort) begin
            n = $fscanf(fd, " %c", cmd);
            if (n != 1)
                break;                      // end of file
            case (cmd)
                "#": n = $fgets(text, fd);
                "P": begin
                    n = $fscanf(fd, "%h", a);
                    park(a);
                end
                "O": begin
                    n = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                    write_object(a, b, c, d, e);
                end
                "R": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    rom[a]        = 16'(b);
                    rom_loaded[a] = 1'b1;
                end
                "L": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    exp_reqs   = b;
                    exp_pulses = 1;
                    run_line(8'(a));
                end
                "E": begin
                    n = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                    expect_run(a, b, c, d, e);
                end
                "V": read_line();
                default: begin
                    $display("unknown record type %c in input file", cmd);
                    errors++;
                    abort = 1'b1;
                end
            endcase
        end
        if (fd != 0)
            $fclose(fd);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule
